/* include/issue_cfg.svh */
/*
 * Issue stage configuration
 * Data width, register file size and scoreboard depth
 */

`ifndef ISSUE_CFG_SVH
`define ISSUE_CFG_SVH

// ----------------------------------------------------------------------
// Datapath
// ----------------------------------------------------------------------
`define XLEN 32

// ----------------------------------------------------------------------
// Architectural registers
// ----------------------------------------------------------------------
`define NR_REGS 32
`define REG_ADDR_BITS 5

// ----------------------------------------------------------------------
// Scoreboard
// ----------------------------------------------------------------------
// Depth must be a power of two so the slot pointers wrap for free
`define SB_ENTRIES 4
`define TRANS_ID_BITS 2

`endif

/* src/issue_pkg.sv */
/*
 * Issue stage types
 * Unit and operation encodings, scoreboard entry and dispatch packet
 */

`include "issue_cfg.svh"

package issue_pkg;

  // Target functional unit
  typedef enum logic [1:0] {
    NONE,
    ALU,
    MULT
  } fu_t;

  // Operation within the unit
  typedef enum logic [2:0] {
    ADD,
    SUB,
    AND,
    XOR,
    MUL
  } fu_op_t;

  // One tracked instruction
  typedef struct packed {
    fu_t                         fu;
    fu_op_t                      op;
    logic [`REG_ADDR_BITS-1:0]   rd;
    logic [`REG_ADDR_BITS-1:0]   rs1;
    logic [`REG_ADDR_BITS-1:0]   rs2;
    logic                        use_imm;
    logic [`XLEN-1:0]            imm;
    logic [`TRANS_ID_BITS-1:0]   trans_id;
    logic [`XLEN-1:0]            result;
    logic                        result_valid;
  } sb_entry_t;

  // Registered packet handed to the units
  typedef struct packed {
    fu_t                         fu;
    fu_op_t                      op;
    logic [`XLEN-1:0]            operand_a;
    logic [`XLEN-1:0]            operand_b;
    logic [`TRANS_ID_BITS-1:0]   trans_id;
  } fu_data_t;

  // Unit selected by an operation
  function automatic fu_t op_fu(fu_op_t op);
    return (op == MUL) ? MULT : ALU;
  endfunction

  // Result computed by the units, multiplier keeps the low word
  function automatic logic [`XLEN-1:0] fu_result(fu_op_t op, logic [`XLEN-1:0] a,
                                                 logic [`XLEN-1:0] b);
    case (op)
      ADD:     return a + b;
      SUB:     return a - b;
      AND:     return a & b;
      XOR:     return a ^ b;
      MUL:     return a * b;
      default: return '0;
    endcase
  endfunction

endpackage

/* src/regfile.sv */
/*
 * Register file, two asynchronous read ports and one write port
 * Register 0 reads as zero
 */

`timescale 1ns/1ps
`include "issue_cfg.svh"

module regfile (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic [`REG_ADDR_BITS-1:0] raddr_a_i,
  input  logic [`REG_ADDR_BITS-1:0] raddr_b_i,
  input  logic [`REG_ADDR_BITS-1:0] waddr_i,
  input  logic [`XLEN-1:0]          wdata_i,
  input  logic                      we_i,
  output logic [`XLEN-1:0]          rdata_a_o,
  output logic [`XLEN-1:0]          rdata_b_o
);

  logic [`XLEN-1:0] regs_q [`NR_REGS];

  // Write port, x0 never changes
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `NR_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Read ports
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

/* src/scoreboard.sv */
/*
 * Scoreboard, circular buffer of in-flight instructions
 * Tracks issue, writeback and commit, with clobber flags and forwarding
 */

`timescale 1ns/1ps
`include "issue_cfg.svh"

module scoreboard (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       flush_i,
  // Decode
  input  issue_pkg::sb_entry_t       decoded_instr_i,
  input  logic                       decoded_instr_valid_i,
  output logic                       decoded_instr_ack_o,
  output logic                       sb_full_o,
  // Issue
  output issue_pkg::sb_entry_t       issue_instr_o,
  output logic                       issue_instr_valid_o,
  input  logic                       issue_ack_i,
  output logic [`NR_REGS-1:0]        rd_clobber_o,
  // Operand forwarding
  input  logic [`REG_ADDR_BITS-1:0]  rs1_i,
  output logic [`XLEN-1:0]           rs1_o,
  output logic                       rs1_valid_o,
  input  logic [`REG_ADDR_BITS-1:0]  rs2_i,
  output logic [`XLEN-1:0]           rs2_o,
  output logic                       rs2_valid_o,
  // Writeback
  input  logic                       wb_valid_i,
  input  logic [`TRANS_ID_BITS-1:0]  wb_trans_id_i,
  input  logic [`XLEN-1:0]           wb_data_i,
  // Commit
  output issue_pkg::sb_entry_t       commit_instr_o,
  output logic                       commit_valid_o,
  input  logic                       commit_ack_i
);

  import issue_pkg::*;

  localparam int unsigned IDW = `TRANS_ID_BITS;
  localparam int unsigned CNT_BITS = `TRANS_ID_BITS + 1;
  localparam logic [CNT_BITS-1:0] FULL_CNT = CNT_BITS'(`SB_ENTRIES);

  sb_entry_t                 mem_q [`SB_ENTRIES];
  logic [`SB_ENTRIES-1:0]    issued_q;
  logic [IDW-1:0]            write_ptr_q;
  logic [IDW-1:0]            issue_ptr_q;
  logic [IDW-1:0]            commit_ptr_q;
  logic [CNT_BITS-1:0]       count_q;

  logic                      push;
  logic                      issue_pop;
  logic                      commit_pop;
  sb_entry_t                 new_entry;

  // ----------------------------------------------------------------------
  // Handshakes
  // ----------------------------------------------------------------------
  assign sb_full_o           = (count_q == FULL_CNT);
  assign decoded_instr_ack_o = decoded_instr_valid_i && !sb_full_o;
  assign push                = decoded_instr_ack_o;

  // When full with all pointers equal, the issued flag tells the two cases apart
  assign issue_instr_valid_o = sb_full_o ? !issued_q[issue_ptr_q]
                                         : (issue_ptr_q != write_ptr_q);
  assign issue_instr_o       = mem_q[issue_ptr_q];
  assign issue_pop           = issue_ack_i && issue_instr_valid_o;

  assign commit_instr_o = mem_q[commit_ptr_q];
  assign commit_valid_o = (count_q != '0) && issued_q[commit_ptr_q] &&
                          mem_q[commit_ptr_q].result_valid;
  assign commit_pop     = commit_ack_i && commit_valid_o;

  always_comb begin
    new_entry              = decoded_instr_i;
    new_entry.trans_id     = write_ptr_q;
    new_entry.result_valid = 1'b0;
  end

  // ----------------------------------------------------------------------
  // Clobber flags and youngest-match forwarding
  // ----------------------------------------------------------------------
  always_comb begin
    rd_clobber_o = '0;
    for (int i = 0; i < `SB_ENTRIES; i++) begin
      if (issued_q[i] && !mem_q[i].result_valid) begin
        rd_clobber_o[mem_q[i].rd] = 1'b1;
      end
    end
  end

  // Walk from oldest to youngest, so the last hit wins
  always_comb begin
    logic [IDW-1:0] idx;
    idx         = '0;
    rs1_o       = '0;
    rs1_valid_o = 1'b0;
    rs2_o       = '0;
    rs2_valid_o = 1'b0;
    for (int i = 0; i < `SB_ENTRIES; i++) begin
      idx = commit_ptr_q + IDW'(i);
      if ((i < int'(count_q)) && issued_q[idx]) begin
        if (mem_q[idx].rd == rs1_i) begin
          rs1_o       = mem_q[idx].result;
          rs1_valid_o = mem_q[idx].result_valid;
        end
        if (mem_q[idx].rd == rs2_i) begin
          rs2_o       = mem_q[idx].result;
          rs2_valid_o = mem_q[idx].result_valid;
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Entry storage
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (push && !flush_i) begin
      mem_q[write_ptr_q] <= new_entry;
    end
    if (wb_valid_i) begin
      mem_q[wb_trans_id_i].result       <= wb_data_i;
      mem_q[wb_trans_id_i].result_valid <= 1'b1;
    end
  end

  // Pointers, occupancy and issued flags
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      write_ptr_q  <= '0;
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      count_q      <= '0;
      issued_q     <= '0;
    end else begin
      if (push) begin
        write_ptr_q <= write_ptr_q + 1'b1;
      end
      if (issue_pop) begin
        issued_q[issue_ptr_q] <= 1'b1;
        issue_ptr_q           <= issue_ptr_q + 1'b1;
      end
      if (commit_pop) begin
        issued_q[commit_ptr_q] <= 1'b0;
        commit_ptr_q           <= commit_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_BITS'(push) - CNT_BITS'(commit_pop);
    end
  end

endmodule

/* src/issue_read_operands.sv */
/*
 * Issue and read operands
 * RAW hazard check, operand muxing and registered dispatch to ALU or multiplier
 */

`timescale 1ns/1ps
`include "issue_cfg.svh"

module issue_read_operands (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       flush_i,
  input  logic                       stall_i,
  // From the scoreboard
  input  issue_pkg::sb_entry_t       issue_instr_i,
  input  logic                       issue_instr_valid_i,
  output logic                       issue_ack_o,
  input  logic [`NR_REGS-1:0]        rd_clobber_i,
  // Forwarding lookup
  output logic [`REG_ADDR_BITS-1:0]  rs1_o,
  input  logic [`XLEN-1:0]           rs1_i,
  input  logic                       rs1_valid_i,
  output logic [`REG_ADDR_BITS-1:0]  rs2_o,
  input  logic [`XLEN-1:0]           rs2_i,
  input  logic                       rs2_valid_i,
  // Register file
  output logic [`REG_ADDR_BITS-1:0]  rf_raddr_a_o,
  output logic [`REG_ADDR_BITS-1:0]  rf_raddr_b_o,
  input  logic [`XLEN-1:0]           rf_rdata_a_i,
  input  logic [`XLEN-1:0]           rf_rdata_b_i,
  // Functional units
  output issue_pkg::fu_data_t        fu_data_o,
  output logic                       alu_valid_o,
  output logic                       mult_valid_o,
  input  logic                       flu_ready_i,
  output logic                       stall_issue_o
);

  import issue_pkg::*;

  logic       rs1_zero;
  logic       rs2_zero;
  logic       rs1_fwd;
  logic       rs2_fwd;
  logic       rs1_ready;
  logic       rs2_ready;
  logic       operands_ready;
  fu_data_t   fu_data_d;
  fu_data_t   fu_data_q;
  logic       alu_valid_q;
  logic       mult_valid_q;

  // ----------------------------------------------------------------------
  // Operand lookup
  // ----------------------------------------------------------------------
  assign rs1_o        = issue_instr_i.rs1;
  assign rs2_o        = issue_instr_i.rs2;
  assign rf_raddr_a_o = issue_instr_i.rs1;
  assign rf_raddr_b_o = issue_instr_i.rs2;

  assign rs1_zero = (issue_instr_i.rs1 == '0);
  assign rs2_zero = (issue_instr_i.rs2 == '0);

  // A finished but uncommitted writer always beats the register file
  assign rs1_fwd = !rs1_zero && rs1_valid_i;
  assign rs2_fwd = !rs2_zero && rs2_valid_i;

  // Ready when x0, no pending writer, or the youngest writer has its result
  assign rs1_ready = rs1_zero || !rd_clobber_i[issue_instr_i.rs1] || rs1_fwd;
  assign rs2_ready = issue_instr_i.use_imm || rs2_zero ||
                     !rd_clobber_i[issue_instr_i.rs2] || rs2_fwd;
  assign operands_ready = rs1_ready && rs2_ready;

  assign issue_ack_o   = issue_instr_valid_i && operands_ready && flu_ready_i &&
                         !stall_i && !flush_i;
  assign stall_issue_o = issue_instr_valid_i && !operands_ready;

  // ----------------------------------------------------------------------
  // Dispatch packet
  // ----------------------------------------------------------------------
  always_comb begin
    fu_data_d.fu       = issue_instr_i.fu;
    fu_data_d.op       = issue_instr_i.op;
    fu_data_d.trans_id = issue_instr_i.trans_id;
    fu_data_d.operand_a = rs1_fwd ? rs1_i : rf_rdata_a_i;
    if (issue_instr_i.use_imm) begin
      fu_data_d.operand_b = issue_instr_i.imm;
    end else begin
      fu_data_d.operand_b = rs2_fwd ? rs2_i : rf_rdata_b_i;
    end
  end

  // Payload only moves on a dispatch
  always_ff @(posedge clk_i) begin
    if (issue_ack_o) begin
      fu_data_q <= fu_data_d;
    end
  end

  // Unit strobes, high for one cycle per dispatch
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      alu_valid_q  <= 1'b0;
      mult_valid_q <= 1'b0;
    end else begin
      alu_valid_q  <= issue_ack_o && (issue_instr_i.fu == ALU);
      mult_valid_q <= issue_ack_o && (issue_instr_i.fu == MULT);
    end
  end

  assign fu_data_o    = fu_data_q;
  assign alu_valid_o  = alu_valid_q;
  assign mult_valid_o = mult_valid_q;

endmodule

/* src/issue_stage.sv */
/*
 * Issue stage top level
 * Scoreboard, issue and read operands block and register file
 */

`timescale 1ns/1ps
`include "issue_cfg.svh"

module issue_stage (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       flush_i,
  input  logic                       stall_i,
  // Decode
  input  issue_pkg::sb_entry_t       decoded_instr_i,
  input  logic                       decoded_instr_valid_i,
  output logic                       decoded_instr_ack_o,
  output logic                       sb_full_o,
  // Dispatch
  output issue_pkg::fu_data_t        fu_data_o,
  output logic                       alu_valid_o,
  output logic                       mult_valid_o,
  input  logic                       flu_ready_i,
  output logic                       stall_issue_o,
  // Writeback
  input  logic                       wb_valid_i,
  input  logic [`TRANS_ID_BITS-1:0]  wb_trans_id_i,
  input  logic [`XLEN-1:0]           wb_data_i,
  // Commit
  output issue_pkg::sb_entry_t       commit_instr_o,
  output logic                       commit_valid_o,
  input  logic                       commit_ack_i,
  input  logic [`REG_ADDR_BITS-1:0]  waddr_i,
  input  logic [`XLEN-1:0]           wdata_i,
  input  logic                       we_i
);

  import issue_pkg::*;

  // ----------------------------------------------------------------------
  // Scoreboard to issue block
  // ----------------------------------------------------------------------
  sb_entry_t                   issue_instr;
  logic                        issue_instr_valid;
  logic                        issue_ack;
  logic [`NR_REGS-1:0]         rd_clobber;
  logic [`REG_ADDR_BITS-1:0]   rs1_idx;
  logic [`REG_ADDR_BITS-1:0]   rs2_idx;
  logic [`XLEN-1:0]            rs1_fwd;
  logic [`XLEN-1:0]            rs2_fwd;
  logic                        rs1_fwd_valid;
  logic                        rs2_fwd_valid;

  // Register file read ports
  logic [`REG_ADDR_BITS-1:0]   rf_raddr_a;
  logic [`REG_ADDR_BITS-1:0]   rf_raddr_b;
  logic [`XLEN-1:0]            rf_rdata_a;
  logic [`XLEN-1:0]            rf_rdata_b;

  scoreboard scoreboard_inst (
    .clk_i                 (clk_i),
    .rst_n_i               (rst_n_i),
    .flush_i               (flush_i),
    .decoded_instr_i       (decoded_instr_i),
    .decoded_instr_valid_i (decoded_instr_valid_i),
    .decoded_instr_ack_o   (decoded_instr_ack_o),
    .sb_full_o             (sb_full_o),
    .issue_instr_o         (issue_instr),
    .issue_instr_valid_o   (issue_instr_valid),
    .issue_ack_i           (issue_ack),
    .rd_clobber_o          (rd_clobber),
    .rs1_i                 (rs1_idx),
    .rs1_o                 (rs1_fwd),
    .rs1_valid_o           (rs1_fwd_valid),
    .rs2_i                 (rs2_idx),
    .rs2_o                 (rs2_fwd),
    .rs2_valid_o           (rs2_fwd_valid),
    .wb_valid_i            (wb_valid_i),
    .wb_trans_id_i         (wb_trans_id_i),
    .wb_data_i             (wb_data_i),
    .commit_instr_o        (commit_instr_o),
    .commit_valid_o        (commit_valid_o),
    .commit_ack_i          (commit_ack_i)
  );

  issue_read_operands issue_read_operands_inst (
    .clk_i               (clk_i),
    .rst_n_i             (rst_n_i),
    .flush_i             (flush_i),
    .stall_i             (stall_i),
    .issue_instr_i       (issue_instr),
    .issue_instr_valid_i (issue_instr_valid),
    .issue_ack_o         (issue_ack),
    .rd_clobber_i        (rd_clobber),
    .rs1_o               (rs1_idx),
    .rs1_i               (rs1_fwd),
    .rs1_valid_i         (rs1_fwd_valid),
    .rs2_o               (rs2_idx),
    .rs2_i               (rs2_fwd),
    .rs2_valid_i         (rs2_fwd_valid),
    .rf_raddr_a_o        (rf_raddr_a),
    .rf_raddr_b_o        (rf_raddr_b),
    .rf_rdata_a_i        (rf_rdata_a),
    .rf_rdata_b_i        (rf_rdata_b),
    .fu_data_o           (fu_data_o),
    .alu_valid_o         (alu_valid_o),
    .mult_valid_o        (mult_valid_o),
    .flu_ready_i         (flu_ready_i),
    .stall_issue_o       (stall_issue_o)
  );

  // Commit stage owns the write port
  regfile regfile_inst (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .raddr_a_i (rf_raddr_a),
    .raddr_b_i (rf_raddr_b),
    .waddr_i   (waddr_i),
    .wdata_i   (wdata_i),
    .we_i      (we_i),
    .rdata_a_o (rf_rdata_a),
    .rdata_b_o (rf_rdata_b)
  );

endmodule

/* verif/issue_stage_props.sv */
/*
 * Protocol properties of the issue stage, bound to the top level
 */

`timescale 1ns/1ps

module issue_stage_props (
  input logic clk_i,
  input logic rst_n_i,
  input logic flu_ready_i,
  input logic alu_valid_i,
  input logic mult_valid_i,
  input logic decoded_instr_ack_i,
  input logic sb_full_i
);

  // A unit strobe needs the units ready on the dispatch edge
  unit_valid_needs_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (alu_valid_i || mult_valid_i) |-> $past(flu_ready_i))
    else $error("unit valid after a dispatch with flu_ready_i low");

  // Only one unit per dispatch
  one_unit_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(alu_valid_i && mult_valid_i))
    else $error("alu_valid_o and mult_valid_o high together");

  no_ack_when_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(decoded_instr_ack_i && sb_full_i))
    else $error("decoded_instr_ack_o high with the scoreboard full");

endmodule

bind issue_stage issue_stage_props issue_stage_props_inst (
  .clk_i               (clk_i),
  .rst_n_i             (rst_n_i),
  .flu_ready_i         (flu_ready_i),
  .alu_valid_i         (alu_valid_o),
  .mult_valid_i        (mult_valid_o),
  .decoded_instr_ack_i (decoded_instr_ack_o),
  .sb_full_i           (sb_full_o)
);

/* verif/issue_stage_tb.sv */
/*
 * Testbench for the issue stage
 * Models the ALU, multiplier and commit stage, checks dispatch and commit
 */

`timescale 1ns/1ps
`include "issue_cfg.svh"

module issue_stage_tb;

  import issue_pkg::*;

  localparam int CLK_PERIOD   = 100;
  localparam int NUM_ROWS     = 18;
  localparam int HOLD_CYCLES  = 10;
  localparam int CYCLE_BUDGET = 40;
  localparam int WATCHDOG_NS  = (NUM_ROWS * CYCLE_BUDGET + 50) * CLK_PERIOD;

  // One stimulus row with rs2 unused when use_imm is set
  typedef struct packed {
    fu_op_t                    op;
    logic [`REG_ADDR_BITS-1:0] rd;
    logic [`REG_ADDR_BITS-1:0] rs1;
    logic [`REG_ADDR_BITS-1:0] rs2;
    logic                      use_imm;
    logic [`XLEN-1:0]          imm;
  } row_t;

  // Result held by a unit until its writeback cycle
  typedef struct packed {
    logic [`TRANS_ID_BITS-1:0] tid;
    logic [`XLEN-1:0]          data;
    logic [31:0]               due;
  } wb_item_t;

  logic                      clk_i;
  logic                      rst_n_i;
  logic                      flush_i;
  logic                      stall_i;
  sb_entry_t                 decoded_instr_i;
  logic                      decoded_instr_valid_i;
  logic                      decoded_instr_ack_o;
  logic                      sb_full_o;
  fu_data_t                  fu_data_o;
  logic                      alu_valid_o;
  logic                      mult_valid_o;
  logic                      flu_ready_i;
  logic                      stall_issue_o;
  logic                      wb_valid_i;
  logic [`TRANS_ID_BITS-1:0] wb_trans_id_i;
  logic [`XLEN-1:0]          wb_data_i;
  sb_entry_t                 commit_instr_o;
  logic                      commit_valid_o;
  logic                      commit_ack_i;
  logic [`REG_ADDR_BITS-1:0] waddr_i;
  logic [`XLEN-1:0]          wdata_i;
  logic                      we_i;

  // Stimulus table with expected columns from the reference model
  row_t                      table_q [NUM_ROWS];
  logic [`XLEN-1:0]          exp_a   [NUM_ROWS];
  logic [`XLEN-1:0]          exp_b   [NUM_ROWS];
  logic [`XLEN-1:0]          exp_res [NUM_ROWS];
  logic [`TRANS_ID_BITS-1:0] row_tid [NUM_ROWS];
  logic [`TRANS_ID_BITS-1:0] next_tid;
  wb_item_t                  pend_q [$];
  integer                    seed;

  issue_stage issue_stage_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("TESTBENCH FAILED");
    $fatal(1);
  end

  task automatic check_eq(input logic [`XLEN-1:0] actual, input logic [`XLEN-1:0] expected,
                          input string what);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s is %h, expected %h", $time, what, actual, expected);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  endtask

  // Unit behavior where the multiplier keeps the low word
  function automatic logic [`XLEN-1:0] apply_op(fu_op_t op, logic [`XLEN-1:0] a,
                                                logic [`XLEN-1:0] b);
    case (op)
      ADD:     return a + b;
      SUB:     return a - b;
      AND:     return a & b;
      XOR:     return a ^ b;
      MUL:     return a * b;
      default: return '0;
    endcase
  endfunction

  function automatic sb_entry_t make_entry(row_t row);
    sb_entry_t e;
    e         = '0;
    e.fu      = (row.op == MUL) ? MULT : ALU;
    e.op      = row.op;
    e.rd      = row.rd;
    e.rs1     = row.rs1;
    e.rs2     = row.rs2;
    e.use_imm = row.use_imm;
    e.imm     = row.imm;
    return e;
  endfunction

  // A source waits while its youngest in-flight writer has no result back
  function automatic logic src_waits(logic [`REG_ADDR_BITS-1:0] src, int oldest,
                                     int issued_end);
    logic waits;
    waits = 1'b0;
    if (src != '0) begin
      for (int j = oldest; j < issued_end; j++) begin
        if (table_q[j].rd == src) begin
          waits = 1'b0;
          foreach (pend_q[k]) begin
            if (pend_q[k].tid == row_tid[j]) begin
              waits = 1'b1;
            end
          end
        end
      end
    end
    return waits;
  endfunction

  // ----------------------------------------------------------------------
  // Program and reference register file
  // ----------------------------------------------------------------------
  task automatic load_table();
    logic [`XLEN-1:0] ref_regs [`NR_REGS];
    for (int i = 0; i < `NR_REGS; i++) begin
      ref_regs[i] = '0;
    end
    //            op   rd     rs1    rs2    imm?  imm
    table_q[0]  = '{ADD, 5'd1,  5'd0,  5'd0,  1'b1, 32'd5};
    table_q[1]  = '{ADD, 5'd2,  5'd0,  5'd0,  1'b1, 32'd7};
    table_q[2]  = '{MUL, 5'd3,  5'd1,  5'd2,  1'b0, 32'd0};
    table_q[3]  = '{SUB, 5'd4,  5'd3,  5'd1,  1'b0, 32'd0};
    table_q[4]  = '{XOR, 5'd5,  5'd4,  5'd0,  1'b1, 32'h0000_0f0f};
    table_q[5]  = '{AND, 5'd6,  5'd5,  5'd3,  1'b0, 32'd0};
    table_q[6]  = '{MUL, 5'd7,  5'd6,  5'd0,  1'b1, 32'd3};
    table_q[7]  = '{ADD, 5'd1,  5'd7,  5'd1,  1'b0, 32'd0};
    // Write to x0 is dropped by the register file
    table_q[8]  = '{ADD, 5'd0,  5'd1,  5'd1,  1'b0, 32'd0};
    table_q[9]  = '{SUB, 5'd8,  5'd0,  5'd1,  1'b0, 32'd0};
    table_q[10] = '{MUL, 5'd9,  5'd8,  5'd8,  1'b0, 32'd0};
    table_q[11] = '{ADD, 5'd9,  5'd9,  5'd0,  1'b1, 32'd1};
    table_q[12] = '{XOR, 5'd10, 5'd9,  5'd3,  1'b0, 32'd0};
    table_q[13] = '{AND, 5'd11, 5'd10, 5'd0,  1'b1, 32'h0000_00ff};
    table_q[14] = '{ADD, 5'd12, 5'd11, 5'd10, 1'b0, 32'd0};
    table_q[15] = '{MUL, 5'd13, 5'd12, 5'd12, 1'b0, 32'd0};
    table_q[16] = '{ADD, 5'd14, 5'd13, 5'd0,  1'b0, 32'd0};
    table_q[17] = '{SUB, 5'd15, 5'd14, 5'd1,  1'b0, 32'd0};
    for (int i = 0; i < NUM_ROWS; i++) begin
      exp_a[i]   = ref_regs[table_q[i].rs1];
      exp_b[i]   = table_q[i].use_imm ? table_q[i].imm : ref_regs[table_q[i].rs2];
      exp_res[i] = apply_op(table_q[i].op, exp_a[i], exp_b[i]);
      if (table_q[i].rd != '0) begin
        ref_regs[table_q[i].rd] = exp_res[i];
      end
    end
  endtask

  task automatic check_idle(input string when);
    check_eq(`XLEN'(alu_valid_o), '0, {when, " alu_valid_o"});
    check_eq(`XLEN'(mult_valid_o), '0, {when, " mult_valid_o"});
    check_eq(`XLEN'(commit_valid_o), '0, {when, " commit_valid_o"});
    check_eq(`XLEN'(sb_full_o), '0, {when, " sb_full_o"});
    check_eq(`XLEN'(stall_issue_o), '0, {when, " stall_issue_o"});
  endtask

  // ----------------------------------------------------------------------
  // Apply rows first..last with commit held off for the first hold cycles
  // ----------------------------------------------------------------------
  task automatic run_rows(input int first, input int last, input int hold);
    int       send_idx;
    int       disp_idx;
    int       commit_idx;
    int       cyc;
    int       held_acc;
    row_t     row;
    fu_t      exp_fu;
    wb_item_t item;
    logic     exp_stall;
    send_idx   = first;
    disp_idx   = first;
    commit_idx = first;
    cyc        = 0;
    held_acc   = 0;
    while (commit_idx <= last) begin
      @(negedge clk_i);
      // Units accept the dispatch and schedule a result
      if (alu_valid_o || mult_valid_o) begin
        check_eq(`XLEN'(disp_idx < send_idx), 1, "dispatch without an accepted row");
        row    = table_q[disp_idx];
        exp_fu = (row.op == MUL) ? MULT : ALU;
        check_eq(`XLEN'(alu_valid_o), `XLEN'(exp_fu == ALU), $sformatf("row %0d alu", disp_idx));
        check_eq(`XLEN'(mult_valid_o), `XLEN'(exp_fu == MULT),
                 $sformatf("row %0d mult", disp_idx));
        check_eq(`XLEN'(fu_data_o.fu), `XLEN'(exp_fu), $sformatf("row %0d fu", disp_idx));
        check_eq(`XLEN'(fu_data_o.op), `XLEN'(row.op), $sformatf("row %0d op", disp_idx));
        check_eq(`XLEN'(fu_data_o.trans_id), `XLEN'(row_tid[disp_idx]),
                 $sformatf("row %0d trans_id", disp_idx));
        check_eq(fu_data_o.operand_a, exp_a[disp_idx], $sformatf("row %0d operand_a", disp_idx));
        check_eq(fu_data_o.operand_b, exp_b[disp_idx], $sformatf("row %0d operand_b", disp_idx));
        item.tid  = fu_data_o.trans_id;
        item.data = apply_op(fu_data_o.op, fu_data_o.operand_a, fu_data_o.operand_b);
        item.due  = 32'(cyc + ($random(seed) & 3));
        pend_q.push_back(item);
        disp_idx++;
      end
      // Oldest unissued row waits on a RAW hazard
      exp_stall = 1'b0;
      if (disp_idx < send_idx) begin
        row       = table_q[disp_idx];
        exp_stall = src_waits(row.rs1, commit_idx, disp_idx) ||
                    (!row.use_imm && src_waits(row.rs2, commit_idx, disp_idx));
      end
      check_eq(`XLEN'(stall_issue_o), `XLEN'(exp_stall),
               $sformatf("row %0d stall_issue_o", disp_idx));
      // Single writeback port sends the first due result
      wb_valid_i = 1'b0;
      for (int k = 0; k < pend_q.size(); k++) begin
        if (pend_q[k].due <= 32'(cyc)) begin
          wb_valid_i    = 1'b1;
          wb_trans_id_i = pend_q[k].tid;
          wb_data_i     = pend_q[k].data;
          pend_q.delete(k);
          break;
        end
      end
      // Commit stage
      commit_ack_i = 1'b0;
      we_i         = 1'b0;
      if (commit_valid_o && (cyc >= hold)) begin
        check_eq(`XLEN'(commit_idx < disp_idx), 1, "commit of an undispatched row");
        check_eq(`XLEN'(commit_instr_o.rd), `XLEN'(table_q[commit_idx].rd),
                 $sformatf("row %0d commit rd", commit_idx));
        check_eq(`XLEN'(commit_instr_o.trans_id), `XLEN'(row_tid[commit_idx]),
                 $sformatf("row %0d commit trans_id", commit_idx));
        check_eq(commit_instr_o.result, exp_res[commit_idx],
                 $sformatf("row %0d commit result", commit_idx));
        commit_ack_i = 1'b1;
        we_i         = 1'b1;
        waddr_i      = commit_instr_o.rd;
        wdata_i      = commit_instr_o.result;
        commit_idx++;
      end
      // Decode side
      decoded_instr_valid_i = (send_idx <= last);
      if (send_idx <= last) begin
        decoded_instr_i = make_entry(table_q[send_idx]);
      end
      flu_ready_i = (($random(seed) & 3) != 0);
      #1;
      if (decoded_instr_valid_i && (cyc < hold) && (held_acc == `SB_ENTRIES)) begin
        check_eq(`XLEN'(sb_full_o), 1, "sb_full_o with commit held");
        check_eq(`XLEN'(decoded_instr_ack_o), 0, "decoded_instr_ack_o while full");
      end
      if (decoded_instr_valid_i && decoded_instr_ack_o) begin
        row_tid[send_idx] = next_tid;
        next_tid          = next_tid + 1'b1;
        send_idx++;
        if (cyc < hold) begin
          held_acc++;
        end
      end
      if ((hold > 0) && (cyc == hold - 1)) begin
        check_eq(`XLEN'(held_acc), `SB_ENTRIES, "rows accepted with commit held");
      end
      cyc++;
    end
  endtask

  // Park two rows that never issue, then flush them away
  task automatic flush_check();
    @(negedge clk_i);
    wb_valid_i            = 1'b0;
    commit_ack_i          = 1'b0;
    we_i                  = 1'b0;
    flu_ready_i           = 1'b0;
    decoded_instr_valid_i = 1'b1;
    decoded_instr_i       = make_entry(table_q[0]);
    repeat (2) @(negedge clk_i);
    decoded_instr_valid_i = 1'b0;
    flush_i               = 1'b1;
    @(negedge clk_i);
    flush_i     = 1'b0;
    flu_ready_i = 1'b1;
    next_tid    = '0;
    repeat (3) begin
      @(negedge clk_i);
      check_idle("after flush");
    end
  endtask

  initial begin
    seed                  = 32'h83a0;
    rst_n_i               = 1'b0;
    flush_i               = 1'b0;
    stall_i               = 1'b0;
    decoded_instr_i       = '0;
    decoded_instr_valid_i = 1'b0;
    flu_ready_i           = 1'b0;
    wb_valid_i            = 1'b0;
    wb_trans_id_i         = '0;
    wb_data_i             = '0;
    commit_ack_i          = 1'b0;
    waddr_i               = '0;
    wdata_i               = '0;
    we_i                  = 1'b0;
    next_tid              = '0;
    load_table();
    repeat (4) @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);
    check_idle("after reset");
    check_eq(`XLEN'(decoded_instr_ack_o), 0, "decoded_instr_ack_o with no valid");
    run_rows(0, 9, 0);
    run_rows(10, 15, HOLD_CYCLES);
    flush_check();
    run_rows(16, NUM_ROWS - 1, 0);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

/* list.f */
+incdir+include
src/issue_pkg.sv
src/regfile.sv
src/scoreboard.sv
src/issue_read_operands.sv
src/issue_stage.sv
verif/issue_stage_props.sv
verif/issue_stage_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the issue stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f list.f --top-module issue_stage_tb -o issue_stage_sim \
  && ./obj_dir/issue_stage_sim > sim.log 2>&1 \
  || { echo "Simulation build or run failed"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "TESTBENCH PASSED" sim.log && exit 0 || exit 1
